/* mem_map_pkg.sv */
// address map of the two memory slaves and decoder limits
// bases must be word aligned and regions must not overlap
// word counts must be powers of two, at least 2
package mem_map_pkg;

	// fast RAM, zero wait states
	localparam logic [31:0] FAST_BASE  = 32'h0000_0000;
	localparam int          FAST_WORDS = 256;

	// slow RAM, stalls after every accepted access
	localparam logic [31:0] SLOW_BASE  = 32'h0000_1000;
	localparam int          SLOW_WORDS = 64;
	// stall cycles following each accepted slow access
	localparam int          SLOW_DELAY = 3;

	// outstanding request limit in the decoder
	localparam int MAX_OUTSTANDING = 2;
	// width of the outstanding counter
	localparam int OUT_CNT_W = 2;

	// region codes
	// REG_NONE also marks an idle decoder after reset
	typedef enum logic [1:0] {
		REG_NONE = 2'd0,
		REG_FAST = 2'd1,
		REG_SLOW = 2'd2
	} region_e;

endpackage

/* sim.f */
wb4_bus_pkg.sv
mem_map_pkg.sv
wb4_smem.sv
wb4_decode.sv
wb4_mem_sys.sv
wb4_mem_sys_props.sv
tb_wb4_mem_sys.sv

/* tb_wb4_mem_sys.sv */
// testbench for the Wishbone B4 memory block, one master port
// inputs change 1 ns after the rising edge, outputs sampled on the falling edge
// a shadow model predicts every ack, err and read word in request order
// stops at the first mismatch or timeout
`timescale 1ns/1ps

module tb_wb4_mem_sys
	import wb4_bus_pkg::*;
	import mem_map_pkg::*;
();

	// cycles any single wait may take
	localparam int TIMEOUT = 50;
	localparam int FAST_BYTES = FAST_WORDS * 4;
	localparam int SLOW_BYTES = SLOW_WORDS * 4;
	// slow RAM acceptance spacing
	localparam int SLOW_GAP = SLOW_DELAY + 1;

	typedef struct {
		region_e     region;
		logic        is_read;
		logic [31:0] data;
		int          acc_cycle;
	} resp_t;

	logic                 clk_i;
	logic                 rst_i;
	logic                 wb_cyc_i;
	logic                 wb_stb_i;
	logic                 wb_we_i;
	logic [WB_ADDR_W-1:0] wb_addr_i;
	logic [WB_DATA_W-1:0] wb_data_i;
	logic [WB_SEL_W-1:0]  wb_sel_i;
	logic                 wb_stall_o;
	logic                 wb_ack_o;
	logic                 wb_err_o;
	logic [WB_DATA_W-1:0] wb_data_o;

	// expected responses, oldest first
	resp_t       exp_q[$];
	logic [31:0] fast_shadow [FAST_WORDS];
	logic [31:0] slow_shadow [SLOW_WORDS];
	int          cycle = 0;
	int          last_slow_acc;
	integer      seed;

	wb4_mem_sys u_dut (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_addr_i  (wb_addr_i),
		.wb_data_i  (wb_data_i),
		.wb_sel_i   (wb_sel_i),
		.wb_stall_o (wb_stall_o),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.wb_data_o  (wb_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#2 clk_i = ~clk_i;
		end
	end

	// cycle number, stable at the falling edge
	always @(posedge clk_i) begin
		cycle <= cycle + 1;
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
		abort_run();
	endtask

	task automatic show_problem(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		abort_run();
	endtask

	// reference model, applies the address map and the byte-lane merge
	function automatic resp_t predict(input logic we, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] sel, input int acc);
		resp_t r;
		int    idx;
		logic [31:0] word;
		r.is_read = !we;
		r.acc_cycle = acc;
		r.data = '0;
		word = '0;
		idx = 0;
		if (addr >= FAST_BASE && addr < FAST_BASE + 32'(FAST_BYTES)) begin
			r.region = REG_FAST;
			idx = int'((addr - FAST_BASE) >> 2);
			word = fast_shadow[idx];
		end else if (addr >= SLOW_BASE && addr < SLOW_BASE + 32'(SLOW_BYTES)) begin
			r.region = REG_SLOW;
			idx = int'((addr - SLOW_BASE) >> 2);
			word = slow_shadow[idx];
		end else begin
			r.region = REG_NONE;
		end
		if (we) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (sel[lane]) begin
					word[8*lane +: 8] = data[8*lane +: 8];
				end
			end
			// unmapped writes touch nothing
			if (r.region == REG_FAST) begin
				fast_shadow[idx] = word;
			end else if (r.region == REG_SLOW) begin
				slow_shadow[idx] = word;
			end
		end else begin
			r.data = word;
		end
		return r;
	endfunction

	// one request, held until the DUT drops stall; returns the acceptance cycle
	task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] sel, output int acc);
		int    waited;
		resp_t want;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_addr_i = addr;
		wb_data_i = data;
		wb_sel_i = sel;
		waited = 0;
		@(negedge clk_i);
		while (wb_stall_o) begin
			waited++;
			if (waited > TIMEOUT) begin
				show_problem("request still stalled after timeout");
			end
			@(negedge clk_i);
		end
		// transfers on the coming rising edge
		acc = cycle;
		want = predict(we, addr, data, sel, acc);
		if (want.region == REG_SLOW) begin
			if (last_slow_acc >= 0) begin
				assert (acc - last_slow_acc >= SLOW_GAP)
					else show_problem("slow RAM accepted requests too close together");
			end
			last_slow_acc = acc;
		end
		exp_q.push_back(want);
		@(posedge clk_i);
		#1;
	endtask

	// stop issuing and wait for every response
	task automatic drain();
		int waited;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > TIMEOUT) begin
				show_problem("response missing after timeout");
			end
			@(negedge clk_i);
		end
		@(posedge clk_i);
		#1;
		wb_cyc_i = 1'b0;
	endtask

	task automatic apply_reset();
		rst_i = 1'b1;
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		@(negedge clk_i);
		assert (!wb_ack_o) else show_mismatch("wb_ack_o", 32'h0, 32'(wb_ack_o));
		assert (!wb_err_o) else show_mismatch("wb_err_o", 32'h0, 32'(wb_err_o));
		assert (!wb_stall_o) else show_mismatch("wb_stall_o", 32'h0, 32'(wb_stall_o));
		@(posedge clk_i);
		#1;
	endtask

	// response checker, pops one entry per ack or err
	initial begin : response_check
		resp_t want;
		forever begin
			@(negedge clk_i);
			assert (u_dut.u_decode.u_props.fail_cnt == 0)
				else show_problem("a decoder property assertion failed");
			if (!rst_i && (wb_ack_o || wb_err_o)) begin
				if (exp_q.size() == 0) begin
					show_problem("response seen with no request outstanding");
				end
				want = exp_q.pop_front();
				assert (wb_err_o == (want.region == REG_NONE))
					else show_mismatch("wb_err_o", 32'(want.region == REG_NONE), 32'(wb_err_o));
				assert (wb_ack_o == (want.region != REG_NONE))
					else show_mismatch("wb_ack_o", 32'(want.region != REG_NONE), 32'(wb_ack_o));
				if (want.is_read && want.region != REG_NONE) begin
					assert (wb_data_o == want.data)
						else show_mismatch("wb_data_o", want.data, wb_data_o);
				end
				assert (cycle == want.acc_cycle + 1)
					else show_problem("response not one cycle after acceptance");
			end
		end
	end

	initial begin : stimulus
		int          acc;
		int          prev_acc;
		logic [31:0] rnd;
		logic [31:0] addr;
		seed = 32'h57e2;
		last_slow_acc = -1;
		prev_acc = 0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_addr_i = '0;
		wb_data_i = '0;
		wb_sel_i = '0;
		for (int i = 0; i < FAST_WORDS; i++) begin
			fast_shadow[i] = '0;
		end
		for (int i = 0; i < SLOW_WORDS; i++) begin
			slow_shadow[i] = '0;
		end
		apply_reset();

		// full word, then a partial lane write, in both RAMs
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, FAST_BASE + 32'(i * 4), $random(seed), 4'hf, acc);
			issue(1'b1, FAST_BASE + 32'(i * 4), $random(seed), 4'(1 + i * 5), acc);
			issue(1'b1, SLOW_BASE + 32'(i * 4), $random(seed), 4'hf, acc);
			issue(1'b1, SLOW_BASE + 32'(i * 4), $random(seed), 4'(2 + i * 3), acc);
		end
		for (int i = 0; i < 4; i++) begin
			issue(1'b0, FAST_BASE + 32'(i * 4), '0, 4'hf, acc);
			issue(1'b0, SLOW_BASE + 32'(i * 4), '0, 4'hf, acc);
		end
		drain();

		// fast reads must go out one per cycle
		for (int i = 0; i < 8; i++) begin
			issue(1'b0, FAST_BASE + 32'(i * 4), '0, 4'hf, acc);
			if (i > 0) begin
				assert (acc == prev_acc + 1)
					else show_problem("fast RAM did not accept back-to-back reads");
			end
			prev_acc = acc;
		end
		drain();

		// slow write/read pairs, spacing checked inside issue
		for (int i = 0; i < 6; i++) begin
			issue(i % 2 == 0, SLOW_BASE + 32'(16 + (i / 2) * 4), $random(seed), 4'hf, acc);
		end
		drain();

		// unmapped writes alias word 0 in both RAMs, which must stay unchanged
		issue(1'b1, 32'h0000_0800, 32'hdead_beef, 4'hf, acc);
		issue(1'b1, 32'h0000_2000, 32'hcafe_f00d, 4'hf, acc);
		issue(1'b0, 32'h0000_0800, '0, 4'hf, acc);
		issue(1'b0, 32'h0000_2000, '0, 4'hf, acc);
		issue(1'b0, FAST_BASE, '0, 4'hf, acc);
		issue(1'b0, SLOW_BASE, '0, 4'hf, acc);
		drain();

		// random mix, about half fast, a third slow, rest unmapped
		for (int i = 0; i < 60; i++) begin
			rnd = $random(seed);
			addr = $random(seed);
			if (rnd[2:0] < 3'd4) begin
				addr = FAST_BASE + (addr & 32'(FAST_BYTES - 4));
			end else if (rnd[2:0] < 3'd7) begin
				addr = SLOW_BASE + (addr & 32'(SLOW_BYTES - 4));
			end else begin
				addr = 32'h0000_2000 + (addr & 32'h0000_0ffc);
			end
			issue(rnd[3], addr, $random(seed), rnd[7:4], acc);
		end
		drain();

		// contents survive a reset in mid run
		apply_reset();
		for (int i = 0; i < 4; i++) begin
			issue(1'b0, FAST_BASE + 32'(i * 4), '0, 4'hf, acc);
			issue(1'b0, SLOW_BASE + 32'(i * 4), '0, 4'hf, acc);
		end
		drain();

		if (u_dut.u_decode.u_props.fail_cnt == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

/* wb4_bus_pkg.sv */
// Wishbone B4 pipelined bus widths for the memory subsystem
// only a 32-bit data bus with byte select lanes is supported
// addresses are byte addresses, slaves decode word granularity
package wb4_bus_pkg;

	// data path width in bits
	localparam int WB_DATA_W = 32;

	// byte address width
	// full 32-bit space, the decoder maps only a small part of it
	localparam int WB_ADDR_W = 32;

	// one select bit per byte lane
	localparam int WB_SEL_W = WB_DATA_W / 8;

	// address bits below one word
	// these are ignored by the memories, sel picks the lanes
	localparam int WB_BYTE_OFS_W = 2;

endpackage

/* wb4_decode.sv */
// address decoder and response router for two Wishbone B4 memory slaves
// requests to a new region wait until all earlier responses are back
// unmapped addresses are accepted only when idle and answered with err
// master must keep cyc high while requests are outstanding, no abort
// at most MAX_OUTSTANDING requests in flight
`timescale 1ns/1ps

module wb4_decode
	import wb4_bus_pkg::*;
	import mem_map_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	// master side
	input  logic                 m_cyc_i,
	input  logic                 m_stb_i,
	input  logic [WB_ADDR_W-1:0] m_addr_i,
	output logic                 m_stall_o,
	output logic                 m_ack_o,
	output logic                 m_err_o,
	output logic [WB_DATA_W-1:0] m_data_o,
	// fast RAM side
	output logic                 f_cyc_o,
	output logic                 f_stb_o,
	input  logic                 f_stall_i,
	input  logic                 f_ack_i,
	input  logic [WB_DATA_W-1:0] f_data_i,
	// slow RAM side
	output logic                 s_cyc_o,
	output logic                 s_stb_o,
	input  logic                 s_stall_i,
	input  logic                 s_ack_i,
	input  logic [WB_DATA_W-1:0] s_data_i
);

	// region end addresses, exclusive
	localparam logic [WB_ADDR_W-1:0] FAST_END =
		FAST_BASE + WB_ADDR_W'(FAST_WORDS << WB_BYTE_OFS_W);
	localparam logic [WB_ADDR_W-1:0] SLOW_END =
		SLOW_BASE + WB_ADDR_W'(SLOW_WORDS << WB_BYTE_OFS_W);

	// region of the request on the bus
	region_e req_reg;
	// region owning every outstanding request
	region_e out_reg;
	// requests accepted but not yet answered
	logic [OUT_CNT_W-1:0] out_cnt;

	logic busy;
	logic conflict;
	logic limit_hit;
	logic blocked;
	logic accept;
	logic resp;
	logic err_q;

	// address classification
	always_comb begin
		if (m_addr_i >= FAST_BASE && m_addr_i < FAST_END) begin
			req_reg = REG_FAST;
		end else if (m_addr_i >= SLOW_BASE && m_addr_i < SLOW_END) begin
			req_reg = REG_SLOW;
		end else begin
			req_reg = REG_NONE;
		end
	end

	assign busy = (out_cnt != '0);

	// ordering rule
	// different region, or any unmapped access, waits for a drained counter
	assign conflict  = busy & ((req_reg != out_reg) | (req_reg == REG_NONE));
	assign limit_hit = (out_cnt == OUT_CNT_W'(MAX_OUTSTANDING));
	assign blocked   = conflict | limit_hit;

	// stb only to the selected slave and only when not blocked
	assign f_stb_o = m_stb_i & ~blocked & (req_reg == REG_FAST);
	assign s_stb_o = m_stb_i & ~blocked & (req_reg == REG_SLOW);

	// cyc held while the slave is addressed or still owes a response
	assign f_cyc_o = m_cyc_i & ((req_reg == REG_FAST) | (busy & (out_reg == REG_FAST)));
	assign s_cyc_o = m_cyc_i & ((req_reg == REG_SLOW) | (busy & (out_reg == REG_SLOW)));

	// stall back to the master
	// unmapped requests never stall once the decoder is idle
	always_comb begin
		if (blocked) begin
			m_stall_o = 1'b1;
		end else begin
			case (req_reg)
				REG_FAST: m_stall_o = f_stall_i;
				REG_SLOW: m_stall_o = s_stall_i;
				default:  m_stall_o = 1'b0;
			endcase
		end
	end

	assign accept = m_cyc_i & m_stb_i & ~m_stall_o;

	// err pulse one cycle after an unmapped acceptance
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= accept & (req_reg == REG_NONE);
		end
	end

	assign m_err_o = err_q;

	// ack from the owning slave only
	assign m_ack_o = busy & (((out_reg == REG_FAST) & f_ack_i) |
		((out_reg == REG_SLOW) & s_ack_i));

	// read data mux, valid only with ack
	assign m_data_o = (out_reg == REG_SLOW) ? s_data_i : f_data_i;

	assign resp = m_ack_o | m_err_o;

	// outstanding bookkeeping
	// accept and response in one cycle leave the count as is
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_cnt <= '0;
			out_reg <= REG_NONE;
		end else begin
			case ({accept, resp})
				2'b10:   out_cnt <= out_cnt + 1'b1;
				2'b01:   out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt;
			endcase
			// owner changes only when the counter is drained
			if (accept) begin
				out_reg <= req_reg;
			end
		end
	end

endmodule

/* wb4_mem_sys.sv */
// Wishbone B4 pipelined memory block, one master port
// fast RAM at FAST_BASE, slow RAM with SLOW_DELAY stall cycles at SLOW_BASE
// every accepted request gets one ack or err, in request order
// unmapped addresses answer with err, memory is left untouched
`timescale 1ns/1ps

module wb4_mem_sys
	import wb4_bus_pkg::*;
	import mem_map_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [WB_ADDR_W-1:0] wb_addr_i,
	input  logic [WB_DATA_W-1:0] wb_data_i,
	input  logic [WB_SEL_W-1:0]  wb_sel_i,
	output logic                 wb_stall_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o,
	output logic [WB_DATA_W-1:0] wb_data_o
);

	// fast RAM handshake
	logic                 f_cyc;
	logic                 f_stb;
	logic                 f_stall;
	logic                 f_ack;
	logic [WB_DATA_W-1:0] f_data;

	// slow RAM handshake
	logic                 s_cyc;
	logic                 s_stb;
	logic                 s_stall;
	logic                 s_ack;
	logic [WB_DATA_W-1:0] s_data;

	// routing, ordering and err generation
	wb4_decode u_decode (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.m_cyc_i   (wb_cyc_i),
		.m_stb_i   (wb_stb_i),
		.m_addr_i  (wb_addr_i),
		.m_stall_o (wb_stall_o),
		.m_ack_o   (wb_ack_o),
		.m_err_o   (wb_err_o),
		.m_data_o  (wb_data_o),
		.f_cyc_o   (f_cyc),
		.f_stb_o   (f_stb),
		.f_stall_i (f_stall),
		.f_ack_i   (f_ack),
		.f_data_i  (f_data),
		.s_cyc_o   (s_cyc),
		.s_stb_o   (s_stb),
		.s_stall_i (s_stall),
		.s_ack_i   (s_ack),
		.s_data_i  (s_data)
	);

	// zero wait state RAM
	// address, data, sel and we are shared with the slow RAM
	wb4_smem #(
		.SIZE  (FAST_WORDS),
		.DELAY (0)
	) u_fast_ram (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (f_cyc),
		.wb_stb_i   (f_stb),
		.wb_we_i    (wb_we_i),
		.wb_addr_i  (wb_addr_i),
		.wb_data_i  (wb_data_i),
		.wb_sel_i   (wb_sel_i),
		.wb_stall_o (f_stall),
		.wb_ack_o   (f_ack),
		.wb_data_o  (f_data)
	);

	// slow RAM, one acceptance per SLOW_DELAY + 1 cycles
	wb4_smem #(
		.SIZE  (SLOW_WORDS),
		.DELAY (SLOW_DELAY)
	) u_slow_ram (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wb_cyc_i   (s_cyc),
		.wb_stb_i   (s_stb),
		.wb_we_i    (wb_we_i),
		.wb_addr_i  (wb_addr_i),
		.wb_data_i  (wb_data_i),
		.wb_sel_i   (wb_sel_i),
		.wb_stall_o (s_stall),
		.wb_ack_o   (s_ack),
		.wb_data_o  (s_data)
	);

endmodule

/* wb4_mem_sys_props.sv */
// concurrent decoder checks bound into every wb4_decode
// relies on the decoder's internal out_cnt and out_reg signals
// checks are off while reset is high
`timescale 1ns/1ps

module wb4_decode_props
	import mem_map_pkg::*;
(
	input logic                 clk_i,
	input logic                 rst_i,
	input logic                 m_ack_i,
	input logic                 m_err_i,
	input logic [OUT_CNT_W-1:0] out_cnt_i,
	input region_e              out_reg_i,
	input logic                 f_stb_i,
	input logic                 s_stb_i
);

	// failure count seen by the testbench
	int fail_cnt = 0;

	// one kind of response per cycle
	a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(m_ack_i && m_err_i))
		else begin
			$error("ack and err high in the same cycle");
			fail_cnt++;
		end

	// counter stays within its limit
	a_out_limit: assert property (@(posedge clk_i) disable iff (rst_i)
		out_cnt_i <= OUT_CNT_W'(MAX_OUTSTANDING))
		else begin
			$error("outstanding count above limit");
			fail_cnt++;
		end

	// every response belongs to an accepted request
	a_resp_owned: assert property (@(posedge clk_i) disable iff (rst_i)
		(m_ack_i || m_err_i) |-> (out_cnt_i != '0))
		else begin
			$error("response with nothing outstanding");
			fail_cnt++;
		end

	// at most one slave addressed
	// and only the one whose region owns the outstanding requests
	a_stb_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		!(f_stb_i && s_stb_i) &&
		!(f_stb_i && (out_cnt_i != '0) && (out_reg_i != REG_FAST)) &&
		!(s_stb_i && (out_cnt_i != '0) && (out_reg_i != REG_SLOW)))
		else begin
			$error("stb high to both slaves or to a region that does not own the bus");
			fail_cnt++;
		end

endmodule

bind wb4_decode wb4_decode_props u_props (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.m_ack_i   (m_ack_o),
	.m_err_i   (m_err_o),
	.out_cnt_i (out_cnt),
	.out_reg_i (out_reg),
	.f_stb_i   (f_stb_o),
	.s_stb_i   (s_stb_o)
);

/* wb4_smem.sv */
// Wishbone B4 pipelined static memory slave, 32-bit, byte lanes via sel
// read data and ack come one cycle after acceptance
// DELAY adds that many stall cycles after every accepted request
// SIZE must be a power of two, at least 2; address wraps modulo SIZE
// contents start at zero in simulation and are never reset
`timescale 1ns/1ps

module wb4_smem
	import wb4_bus_pkg::*;
#(
	parameter int SIZE  = 2,
	parameter int DELAY = 0
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [WB_ADDR_W-1:0] wb_addr_i,
	input  logic [WB_DATA_W-1:0] wb_data_i,
	input  logic [WB_SEL_W-1:0]  wb_sel_i,
	output logic                 wb_stall_o,
	output logic                 wb_ack_o,
	output logic [WB_DATA_W-1:0] wb_data_o
);

	// word index width
	localparam int IDX_W = $clog2(SIZE);
	// delay counter needs to hold DELAY itself, keep 1 bit minimum
	localparam int CNT_W = (DELAY > 0) ? $clog2(DELAY + 1) : 1;

	// storage
	logic [WB_DATA_W-1:0] mem [SIZE];

	// stall counter, nonzero means busy
	logic [CNT_W-1:0] delay_cnt;

	logic [IDX_W-1:0]     word_idx;
	logic [WB_DATA_W-1:0] lane_mask;
	logic [WB_DATA_W-1:0] old_word;
	logic [WB_DATA_W-1:0] wr_word;
	logic                 accept;

	// zero contents at time zero
	initial begin
		for (int i = 0; i < SIZE; i++) begin
			mem[i] = '0;
		end
	end

	// byte offset dropped, upper bits wrap
	assign word_idx = wb_addr_i[WB_BYTE_OFS_W +: IDX_W];

	// stall straight from the counter
	assign wb_stall_o = (delay_cnt != '0);

	// request transfers this edge
	assign accept = wb_cyc_i & wb_stb_i & ~wb_stall_o;

	// expand sel into a bit mask
	always_comb begin
		for (int lane = 0; lane < WB_SEL_W; lane++) begin
			lane_mask[8*lane +: 8] = {8{wb_sel_i[lane]}};
		end
	end

	// read-modify-write merge, unselected lanes keep old bytes
	assign old_word = mem[word_idx];
	assign wr_word  = (wb_data_i & lane_mask) | (old_word & ~lane_mask);

	// memory array and read register
	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (wb_we_i) begin
				mem[word_idx] <= wr_word;
			end else begin
				// read data lines up with ack
				wb_data_o <= old_word;
			end
		end
	end

	// ack one cycle after acceptance, for reads and writes alike
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= accept;
		end
	end

	// access delay
	// load on acceptance, count down to zero, then accept again
	// with DELAY 0 the counter stays at zero
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			delay_cnt <= '0;
		end else if (delay_cnt != '0) begin
			delay_cnt <= delay_cnt - 1'b1;
		end else if (accept) begin
			delay_cnt <= CNT_W'(DELAY);
		end
	end

endmodule
